// ==== include/flash_defs.svh ====
// SPI flash read controller constants
// Bus widths, read opcode and transaction lengths in serial-clock cycles

`ifndef FLASH_DEFS_SVH
`define FLASH_DEFS_SVH

// Word address width of the memory port
`define FLASH_AW 22

// Data width of both bus ports
`define FLASH_DW 32

// Slow read opcode without dummy cycles
`define FLASH_CMD_READ 8'h03

// Full read of 8 command, 24 address and 32 data cycles plus the final one
`define FLASH_READ_CYCLES 65

// One raw byte in user mode, plus the final cycle
`define FLASH_BYTE_CYCLES 9

// Constant marker bit in the control word
`define FLASH_CTRL_MARK 12

`endif

// ==== hdl/flash_bus_pkg.sv ====
// Bus-side types of the flash controller
// Requests from the memory and configuration ports, and the merged request

`include "flash_defs.svh"

package flash_bus_pkg;

	// Memory port request
	typedef struct packed {
		logic                   cyc;
		logic                   stb;
		logic                   we;
		logic [`FLASH_AW-1:0]   addr;
	} mem_req_t;

	// Configuration port request
	// rel high leaves user mode, low sends data out on MOSI
	typedef struct packed {
		logic       cyc;
		logic       stb;
		logic       we;
		logic       rel;
		logic [7:0] data;
	} cfg_req_t;

	// Request of the granted port, as seen by the sequencer
	typedef struct packed {
		logic                   cyc;
		logic                   stb;
		logic                   we;
		logic                   cfg_sel;
		logic                   rel;
		logic [7:0]             data;
		logic [`FLASH_AW-1:0]   addr;
	} bus_req_t;

endpackage

// ==== hdl/flash_spi_pkg.sv ====
// Flash-side types of the flash controller
// Opcode, sequencer phase, launch record and SPI pin bundle

`include "flash_defs.svh"

package flash_spi_pkg;

	// Only the slow read command is issued by the controller
	typedef enum logic [7:0] {
		CMD_READ = `FLASH_CMD_READ
	} flash_cmd_e;

	// Transaction in flight
	typedef enum logic [1:0] {
		PH_IDLE,
		PH_READ,
		PH_USER_BYTE
	} xfer_phase_e;

	// One-cycle load of the outgoing shift register
	typedef struct packed {
		logic                   valid;
		xfer_phase_e            kind;
		logic [7:0]             first_byte;
		logic [`FLASH_AW-1:0]   addr;
	} launch_t;

	// Outgoing SPI pins
	typedef struct packed {
		logic cs_n;
		logic sck;
		logic mosi;
	} spi_pins_t;

endpackage

// ==== hdl/flash_port_arbiter.sv ====
// Fixed-priority arbiter between the memory and configuration ports
// The granted port drives the shared sequencer, the other one is held off

`timescale 1ns/1ns

module flash_port_arbiter (
	input  logic                     i_clk,
	input  logic                     i_reset,
	input  flash_bus_pkg::mem_req_t  i_mem,
	input  flash_bus_pkg::cfg_req_t  i_cfg,
	input  logic                     i_stall,
	input  logic                     i_ack,
	output flash_bus_pkg::bus_req_t  o_req,
	output logic                     o_mem_stall,
	output logic                     o_mem_ack,
	output logic                     o_cfg_stall,
	output logic                     o_cfg_ack
);

	// High while the configuration port owns the sequencer
	logic grant_cfg;

	//////////////////////////////////////////////////
	// Grant register
	//////////////////////////////////////////////////

	// Memory port wins whenever it asks
	// Configuration port only gets in when memory is idle
	// Grant is kept as long as the owner holds its cycle
	always_ff @(posedge i_clk)
	begin
		if (i_reset)
			grant_cfg <= 1'b0;
		else if (grant_cfg)
			grant_cfg <= i_cfg.cyc;
		else
			grant_cfg <= !i_mem.cyc && i_cfg.cyc;
	end

	//////////////////////////////////////////////////
	// Request merge
	//////////////////////////////////////////////////

	always_comb
	begin
		// Handshake lines follow the owner
		o_req.cyc     = grant_cfg ? i_cfg.cyc : i_mem.cyc;
		o_req.stb     = grant_cfg ? i_cfg.stb : i_mem.stb;
		o_req.we      = grant_cfg ? i_cfg.we  : i_mem.we;
		o_req.cfg_sel = grant_cfg;
		// Payload fields only matter for their own port
		o_req.rel     = i_cfg.rel;
		o_req.data    = i_cfg.data;
		o_req.addr    = i_mem.addr;
	end

	//////////////////////////////////////////////////
	// Stall and ack steering
	//////////////////////////////////////////////////

	// Loser always sees stall, so it keeps its request up
	assign o_mem_stall = grant_cfg ? 1'b1 : i_stall;
	assign o_cfg_stall = grant_cfg ? i_stall : 1'b1;

	// Ack goes back to the owner only
	assign o_mem_ack = !grant_cfg && i_ack;
	assign o_cfg_ack = grant_cfg && i_ack;

endmodule

// ==== hdl/flash_xfer_sequencer.sv ====
// Transaction sequencer of the flash controller
// Times each SPI transaction and drives stall, ack, chip select and serial clock

`timescale 1ns/1ns

`include "flash_defs.svh"

module flash_xfer_sequencer (
	input  logic                     i_clk,
	input  logic                     i_reset,
	input  flash_bus_pkg::bus_req_t  i_req,
	output logic                     o_stall,
	output logic                     o_ack,
	output flash_spi_pkg::launch_t   o_launch,
	output logic                     o_cs_n,
	output logic                     o_sck,
	output logic                     o_user_mode
);

	localparam int CNT_W = $clog2(`FLASH_READ_CYCLES + 1);

	flash_spi_pkg::xfer_phase_e phase;
	// Cycles left until the ack
	logic [CNT_W-1:0] delay;

	logic accept;
	logic read_start;
	logic user_start;
	logic cfg_write;

	//////////////////////////////////////////////////
	// Request decode
	//////////////////////////////////////////////////

	assign accept = i_req.cyc && i_req.stb && !o_stall;

	// Memory read goes to the flash only outside user mode
	assign read_start = accept && !i_req.cfg_sel && !i_req.we && !o_user_mode;

	// Any configuration write changes the user mode flag
	assign cfg_write = accept && i_req.cfg_sel && i_req.we;

	// Write with release low shifts one byte
	assign user_start = cfg_write && !i_req.rel;

	//////////////////////////////////////////////////
	// Phase and delay counter
	//////////////////////////////////////////////////

	// Dropped cycle clears the counter at once
	always_ff @(posedge i_clk)
	begin
		if (i_reset || !i_req.cyc)
		begin
			phase <= flash_spi_pkg::PH_IDLE;
			delay <= '0;
		end
		else if (read_start)
		begin
			phase <= flash_spi_pkg::PH_READ;
			delay <= CNT_W'(`FLASH_READ_CYCLES);
		end
		else if (user_start)
		begin
			phase <= flash_spi_pkg::PH_USER_BYTE;
			delay <= CNT_W'(`FLASH_BYTE_CYCLES);
		end
		else if (phase != flash_spi_pkg::PH_IDLE)
		begin
			delay <= delay - CNT_W'(1);
			// Ack goes out after the last count
			if (delay == CNT_W'(1))
				phase <= flash_spi_pkg::PH_IDLE;
		end
	end

	//////////////////////////////////////////////////
	// Launch record
	//////////////////////////////////////////////////

	// Valid only in the accepting cycle
	always_comb
	begin
		o_launch.valid = read_start || user_start;
		o_launch.addr  = i_req.addr;
		if (read_start)
		begin
			o_launch.kind       = flash_spi_pkg::PH_READ;
			o_launch.first_byte = flash_spi_pkg::CMD_READ;
		end
		else
		begin
			o_launch.kind       = flash_spi_pkg::PH_USER_BYTE;
			o_launch.first_byte = i_req.data;
		end
	end

	//////////////////////////////////////////////////
	// Bus handshake
	//////////////////////////////////////////////////

	// Stall from the start until the ack cycle
	always_ff @(posedge i_clk)
	begin
		if (i_reset || !i_req.cyc)
			o_stall <= 1'b0;
		else if (read_start || user_start)
			o_stall <= 1'b1;
		else
			o_stall <= (delay > CNT_W'(1));
	end

	// End of a transaction, or an immediate answer
	// No ack once the cycle is gone
	always_ff @(posedge i_clk)
	begin
		if (i_reset)
			o_ack <= 1'b0;
		else if (delay == CNT_W'(1))
			o_ack <= i_req.cyc;
		else
			o_ack <= accept && !read_start && !user_start;
	end

	//////////////////////////////////////////////////
	// User mode, chip select and serial clock
	//////////////////////////////////////////////////

	// Kept through aborts and changed only by a config write
	always_ff @(posedge i_clk)
	begin
		if (i_reset)
			o_user_mode <= 1'b0;
		else if (cfg_write)
			o_user_mode <= !i_req.rel;
	end

	always_ff @(posedge i_clk)
	begin
		if (i_reset)
			o_cs_n <= 1'b1;
		else if (!i_req.cyc && !o_user_mode)
			o_cs_n <= 1'b1;
		else if (read_start)
			o_cs_n <= 1'b0;
		else if (cfg_write)
			o_cs_n <= i_req.rel;
		else if (o_user_mode)
			o_cs_n <= 1'b0;
		else if (delay == CNT_W'(1))
			o_cs_n <= 1'b1;
	end

	// Runs for 64 cycles on a read, 8 on a user byte
	always_ff @(posedge i_clk)
	begin
		if (i_reset)
			o_sck <= 1'b0;
		else if (read_start || user_start)
			o_sck <= 1'b1;
		else
			o_sck <= i_req.cyc && (delay > CNT_W'(2));
	end

endmodule

// ==== hdl/flash_shift_datapath.sv ====
// Shift datapath of the flash controller
// Sends command, address or user byte on MOSI and gathers MISO bits

`timescale 1ns/1ns

`include "flash_defs.svh"

module flash_shift_datapath (
	input  logic                    i_clk,
	input  flash_spi_pkg::launch_t  i_launch,
	input  logic                    i_sck,
	input  logic                    i_user_mode,
	input  logic                    i_miso,
	output logic                    o_mosi,
	output logic [`FLASH_DW-1:0]    o_data
);

	// Leading idle bit, first byte, then the 24-bit byte address
	localparam int ADDR_BITS = `FLASH_AW + 2;
	localparam int SHIFT_W   = 1 + 8 + ADDR_BITS;

	logic [SHIFT_W-1:0]   shift_q;
	logic [ADDR_BITS-1:0] addr_bits;
	// Serial clock one cycle late
	logic                 sck_d;
	logic [7:0]           reply_next;
	logic [`FLASH_DW-1:0] ctrl_word;

	//////////////////////////////////////////////////
	// Outgoing shift register
	//////////////////////////////////////////////////

	// Word address becomes a byte address
	// Nothing follows a user byte
	always_comb
	begin
		if (i_launch.kind == flash_spi_pkg::PH_READ)
			addr_bits = {i_launch.addr, 2'b00};
		else
			addr_bits = '0;
	end

	always_ff @(posedge i_clk)
	begin
		if (i_launch.valid)
			shift_q <= {1'b0, i_launch.first_byte, addr_bits};
		else if (i_sck)
			shift_q <= {shift_q[SHIFT_W-2:0], 1'b0};
	end

	// MSB first
	assign o_mosi = shift_q[SHIFT_W-1];

	//////////////////////////////////////////////////
	// Incoming data
	//////////////////////////////////////////////////

	always_ff @(posedge i_clk)
	begin
		sck_d <= i_sck;
	end

	// Reply byte takes a new bit on each sampling cycle
	assign reply_next = sck_d ? {o_data[6:0], i_miso} : o_data[7:0];

	// Control word seen in user mode
	always_comb
	begin
		ctrl_word = '0;
		ctrl_word[`FLASH_CTRL_MARK] = 1'b1;
		ctrl_word[7:0] = reply_next;
	end

	// Full read word outside user mode
	always_ff @(posedge i_clk)
	begin
		if (i_user_mode)
			o_data <= ctrl_word;
		else if (sck_d)
			o_data <= {o_data[`FLASH_DW-2:0], i_miso};
	end

endmodule

// ==== hdl/flash_ctrl_top.sv ====
// SPI flash read controller, top level
// Memory port reads words, configuration port sends raw bytes

`timescale 1ns/1ns

`include "flash_defs.svh"

module flash_ctrl_top (
	input  logic                      i_clk,
	input  logic                      i_reset,
	input  flash_bus_pkg::mem_req_t   i_mem,
	output logic                      o_mem_stall,
	output logic                      o_mem_ack,
	output logic [`FLASH_DW-1:0]      o_mem_data,
	input  flash_bus_pkg::cfg_req_t   i_cfg,
	output logic                      o_cfg_stall,
	output logic                      o_cfg_ack,
	output logic [`FLASH_DW-1:0]      o_cfg_data,
	output flash_spi_pkg::spi_pins_t  o_spi,
	input  logic                      i_spi_miso
);

	flash_bus_pkg::bus_req_t bus_req;
	flash_spi_pkg::launch_t  launch;
	logic                    bus_stall;
	logic                    bus_ack;
	logic                    cs_n;
	logic                    sck;
	logic                    mosi;
	logic                    user_mode;
	// One data register serves both ports
	logic [`FLASH_DW-1:0]    rd_data;

	flash_port_arbiter u_arbiter (
		.i_clk       (i_clk),
		.i_reset     (i_reset),
		.i_mem       (i_mem),
		.i_cfg       (i_cfg),
		.i_stall     (bus_stall),
		.i_ack       (bus_ack),
		.o_req       (bus_req),
		.o_mem_stall (o_mem_stall),
		.o_mem_ack   (o_mem_ack),
		.o_cfg_stall (o_cfg_stall),
		.o_cfg_ack   (o_cfg_ack)
	);

	flash_xfer_sequencer u_sequencer (
		.i_clk       (i_clk),
		.i_reset     (i_reset),
		.i_req       (bus_req),
		.o_stall     (bus_stall),
		.o_ack       (bus_ack),
		.o_launch    (launch),
		.o_cs_n      (cs_n),
		.o_sck       (sck),
		.o_user_mode (user_mode)
	);

	flash_shift_datapath u_datapath (
		.i_clk       (i_clk),
		.i_launch    (launch),
		.i_sck       (sck),
		.i_user_mode (user_mode),
		.i_miso      (i_spi_miso),
		.o_mosi      (mosi),
		.o_data      (rd_data)
	);

	// Pin bundle
	assign o_spi.cs_n = cs_n;
	assign o_spi.sck  = sck;
	assign o_spi.mosi = mosi;

	assign o_mem_data = rd_data;
	assign o_cfg_data = rd_data;

endmodule

// ==== dv/spi_flash_model.sv ====
// Behavioral SPI flash for the controller testbench
// Decodes slow reads, answers from a word table, shifts reply bytes in user mode

`timescale 1ns/1ns

`include "flash_defs.svh"

module spi_flash_model (
	input  logic                      i_clk,
	input  flash_spi_pkg::spi_pins_t  i_spi,
	input  logic                      i_user_xfer,
	input  logic [`FLASH_AW-1:0]      i_exp_addr,
	input  logic [7:0]                i_reply,
	input  logic [`FLASH_DW-1:0]      i_table [256],
	output logic                      o_miso,
	output logic [7:0]                o_rx_byte,
	output int                        o_err_count
);

	// Serial clock of the previous cycle marks a sampling cycle
	logic                 sck_prev = 1'b0;
	logic                 miso_q = 1'b0;
	logic [7:0]           cmd_rx = 8'h00;
	logic [7:0]           rx_byte = 8'h00;
	logic [23:0]          addr_rx = 24'h0;
	logic [`FLASH_DW-1:0] word = '0;
	int                   cnt = 0;
	int                   err_count = 0;

	assign o_miso      = miso_q;
	assign o_rx_byte   = rx_byte;
	assign o_err_count = err_count;

	always @(posedge i_clk)
	begin
		if (i_spi.cs_n)
			cnt = 0;
		else
		begin
			if (sck_prev)
			begin
				cnt = cnt + 1;
				if (i_user_xfer)
				begin
					if (cnt <= 8)
						rx_byte = {rx_byte[6:0], i_spi.mosi};
				end
				else if (cnt <= 8)
				begin
					cmd_rx = {cmd_rx[6:0], i_spi.mosi};
					if (cnt == 8)
						assert (cmd_rx == `FLASH_CMD_READ) else
						begin
							$display("Error: %0t ns flash opcode got %h expected %h",
								$time, cmd_rx, `FLASH_CMD_READ);
							err_count++;
						end
				end
				else if (cnt <= 32)
				begin
					addr_rx = {addr_rx[22:0], i_spi.mosi};
					if (cnt == 32)
					begin
						assert (addr_rx == {i_exp_addr, 2'b00}) else
						begin
							$display("Error: %0t ns flash address got %h expected %h",
								$time, addr_rx, {i_exp_addr, 2'b00});
							err_count++;
						end
						// Table indexed by the low word address bits
						word = i_table[addr_rx[9:2]];
					end
				end
			end
			else
				cnt = 0;
			// Next cycle samples, so put its bit out now
			if (i_spi.sck)
			begin
				if (i_user_xfer && cnt + 1 <= 8)
					miso_q <= i_reply[7 - cnt];
				else if (!i_user_xfer && cnt + 1 >= 33 && cnt + 1 <= 64)
					miso_q <= word[63 - cnt];
			end
		end
		sck_prev = i_spi.sck;
	end

endmodule

// ==== dv/tb_flash_ctrl.sv ====
// Testbench for the SPI flash read controller
// Random reads, writes and user bytes checked against a flash model and table

`timescale 1ns/1ns

`include "flash_defs.svh"

module tb_flash_ctrl;

	localparam int N_READ  = 12;
	localparam int N_WRITE = 4;
	localparam int N_USER  = 4;
	localparam int N_UMODE = 4;
	localparam int N_ABORT = 2;
	// Plain reads, one after release, and each aborted read with its follow-up
	localparam int TIMEOUT_CYCLES = (N_READ + 1 + 2 * N_ABORT) * 70
		+ (N_WRITE + N_USER + N_UMODE + 1) * 15 + 200;

	logic                      clk;
	logic                      reset;
	flash_bus_pkg::mem_req_t   mem_req;
	flash_bus_pkg::cfg_req_t   cfg_req;
	logic                      mem_stall;
	logic                      mem_ack;
	logic [`FLASH_DW-1:0]      mem_data;
	logic                      cfg_stall;
	logic                      cfg_ack;
	logic [`FLASH_DW-1:0]      cfg_data;
	flash_spi_pkg::spi_pins_t  spi;
	logic                      miso;
	logic                      user_xfer;
	logic [`FLASH_AW-1:0]      exp_addr;
	logic [7:0]                reply;
	logic [7:0]                rx_byte;
	logic [`FLASH_DW-1:0]      flash_table [256];
	int                        model_errs;
	int                        errors = 0;
	int                        checks = 0;
	int                        cycle_count = 0;
	logic [31:0]               lfsr_state = 32'h01c14f95;

	flash_ctrl_top u_dut (
		.i_clk       (clk),
		.i_reset     (reset),
		.i_mem       (mem_req),
		.o_mem_stall (mem_stall),
		.o_mem_ack   (mem_ack),
		.o_mem_data  (mem_data),
		.i_cfg       (cfg_req),
		.o_cfg_stall (cfg_stall),
		.o_cfg_ack   (cfg_ack),
		.o_cfg_data  (cfg_data),
		.o_spi       (spi),
		.i_spi_miso  (miso)
	);

	spi_flash_model u_flash (
		.i_clk       (clk),
		.i_spi       (spi),
		.i_user_xfer (user_xfer),
		.i_exp_addr  (exp_addr),
		.i_reply     (reply),
		.i_table     (flash_table),
		.o_miso      (miso),
		.o_rx_byte   (rx_byte),
		.o_err_count (model_errs)
	);

	initial
	begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// Run limit
	always @(posedge clk)
	begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES)
		begin
			$display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("FAIL: see errors above");
			$finish;
		end
	end

	////////////////////////////////////////////////////
	// Helpers
	////////////////////////////////////////////////////

	// Galois LFSR with polynomial x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		if (s[0])
			return (s >> 1) ^ 32'h80200003;
		return s >> 1;
	endfunction

	task automatic rand_bits(input int n, output logic [31:0] v);
		int i;
		v = '0;
		for (i = 0; i < n; i++)
		begin
			lfsr_state = lfsr_step(lfsr_state);
			v = {v[30:0], lfsr_state[0]};
		end
	endtask

	function automatic int total_errors();
		return errors + model_errs;
	endfunction

	task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
		checks++;
		assert (got === exp) else
		begin
			$display("Error: %0t ns %s got %h expected %h", $time, name, got, exp);
			errors++;
		end
	endtask

	task automatic check_true(input logic cond, input string what);
		checks++;
		assert (cond) else
		begin
			$display("Failure at %0t ns: %s", $time, what);
			errors++;
		end
	endtask

	// Inputs change and outputs are read 5 ns after the rising edge
	task automatic next_cycle();
		@(posedge clk);
		#5;
	endtask

	task automatic idle_gap();
		logic [31:0] v;
		rand_bits(2, v);
		repeat (v[1:0])
			next_cycle();
	endtask

	// Runs one bus request held through stall and counts cycles to the ack
	task automatic bus_xfer(input logic to_cfg, input logic we, input logic rel,
		input logic [7:0] data, input logic [`FLASH_AW-1:0] addr,
		output logic [31:0] rdata, output int ack_cycles, output int sck_cycles);
		ack_cycles = 0;
		sck_cycles = 0;
		if (to_cfg)
			cfg_req = '{cyc: 1'b1, stb: 1'b1, we: we, rel: rel, data: data};
		else
			mem_req = '{cyc: 1'b1, stb: 1'b1, we: we, addr: addr};
		while (to_cfg ? cfg_stall : mem_stall)
			next_cycle();
		// Accepting edge
		next_cycle();
		cfg_req.stb = 1'b0;
		mem_req.stb = 1'b0;
		while (!(to_cfg ? cfg_ack : mem_ack))
		begin
			if (spi.sck)
				sck_cycles++;
			next_cycle();
			ack_cycles++;
		end
		// Ack cycle is sampled too so an immediate answer shows any stray clock
		if (spi.sck)
			sck_cycles++;
		rdata = to_cfg ? cfg_data : mem_data;
		cfg_req.cyc = 1'b0;
		mem_req.cyc = 1'b0;
	endtask

	task automatic mem_read_check();
		logic [31:0] v;
		logic [31:0] rd;
		int ac;
		int sc;
		rand_bits(`FLASH_AW, v);
		exp_addr = v[`FLASH_AW-1:0];
		bus_xfer(1'b0, 1'b0, 1'b0, 8'h00, exp_addr, rd, ac, sc);
		check_val("o_mem_data", rd, flash_table[exp_addr[7:0]]);
		check_val("read ack delay", ac, `FLASH_READ_CYCLES);
		check_val("o_spi.cs_n", 32'(spi.cs_n), 32'd1);
		idle_gap();
	endtask

	function automatic void report_test(input string name, input int mark);
		$display("Test %s finished with %0d errors", name, total_errors() - mark);
	endfunction

	////////////////////////////////////////////////////
	// Stimulus
	////////////////////////////////////////////////////

	initial
	begin
		logic [31:0] v;
		logic [31:0] rd;
		logic [31:0] ctrl;
		int ac;
		int sc;
		int mark;
		int i;
		reset = 1'b1;
		mem_req = '0;
		cfg_req = '0;
		user_xfer = 1'b0;
		exp_addr = '0;
		reply = 8'h00;
		ctrl = '0;
		for (i = 0; i < 256; i++)
		begin
			rand_bits(32, v);
			flash_table[i] = v;
		end
		repeat (8)
			@(posedge clk);
		#5;
		reset = 1'b0;

		// Idle outputs after reset
		mark = total_errors();
		check_val("o_spi.cs_n", 32'(spi.cs_n), 32'd1);
		check_val("o_spi.sck", 32'(spi.sck), 32'd0);
		check_val("o_mem_stall", 32'(mem_stall), 32'd0);
		check_val("o_mem_ack", 32'(mem_ack), 32'd0);
		for (i = 0; i < N_READ; i++)
			mem_read_check();
		report_test("memory read", mark);

		mark = total_errors();
		for (i = 0; i < N_WRITE; i++)
		begin
			rand_bits(`FLASH_AW, v);
			bus_xfer(1'b0, 1'b1, 1'b0, 8'h00, v[`FLASH_AW-1:0], rd, ac, sc);
			check_val("write ack delay", ac, 0);
			check_val("sck cycles", sc, 0);
			check_val("o_spi.cs_n", 32'(spi.cs_n), 32'd1);
			idle_gap();
		end
		report_test("memory write", mark);

		// Each raw byte's reply comes back with the marker bit
		mark = total_errors();
		for (i = 0; i < N_USER; i++)
		begin
			rand_bits(8, v);
			reply = v[7:0];
			rand_bits(8, v);
			user_xfer = 1'b1;
			bus_xfer(1'b1, 1'b1, 1'b0, v[7:0], '0, rd, ac, sc);
			user_xfer = 1'b0;
			ctrl = (32'd1 << `FLASH_CTRL_MARK) | {24'd0, reply};
			check_val("o_cfg_data", rd, ctrl);
			check_val("user ack delay", ac, `FLASH_BYTE_CYCLES);
			check_val("flash rx byte", {24'd0, rx_byte}, {24'd0, v[7:0]});
			check_val("o_spi.cs_n", 32'(spi.cs_n), 32'd0);
			idle_gap();
		end
		report_test("user byte", mark);

		mark = total_errors();
		for (i = 0; i < N_UMODE; i++)
		begin
			rand_bits(1, v);
			if (v[0])
				bus_xfer(1'b1, 1'b0, 1'b0, 8'h00, '0, rd, ac, sc);
			else
			begin
				rand_bits(`FLASH_AW, v);
				bus_xfer(1'b0, 1'b0, 1'b0, 8'h00, v[`FLASH_AW-1:0], rd, ac, sc);
			end
			check_val("control word", rd, ctrl);
			check_val("ack delay", ac, 0);
			check_val("sck cycles", sc, 0);
			idle_gap();
		end
		report_test("user mode reads", mark);

		mark = total_errors();
		bus_xfer(1'b1, 1'b1, 1'b1, 8'h00, '0, rd, ac, sc);
		check_val("release ack delay", ac, 0);
		check_val("o_spi.cs_n", 32'(spi.cs_n), 32'd1);
		idle_gap();
		mem_read_check();
		report_test("leave user mode", mark);

		// Drop the cycle in the middle of a read
		mark = total_errors();
		for (i = 0; i < N_ABORT; i++)
		begin
			rand_bits(`FLASH_AW, v);
			exp_addr = v[`FLASH_AW-1:0];
			mem_req = '{cyc: 1'b1, stb: 1'b1, we: 1'b0, addr: exp_addr};
			next_cycle();
			mem_req.stb = 1'b0;
			rand_bits(5, v);
			repeat (5 + int'(v[4:0]))
			begin
				check_true(!mem_ack, "ack came before the aborted read ended");
				check_true(mem_stall, "stall low while the read is in flight");
				check_true(cfg_stall, "configuration port not held off during a read");
				next_cycle();
			end
			mem_req.cyc = 1'b0;
			next_cycle();
			check_true(spi.cs_n, "chip select still low after abort");
			check_true(!spi.sck, "serial clock still running after abort");
			check_true(!mem_stall, "stall still high after abort");
			check_true(!mem_ack, "ack given for an aborted read");
			next_cycle();
			check_true(!mem_ack, "late ack given for an aborted read");
			mem_read_check();
		end
		report_test("abort", mark);

		$display("Totals: %0d checks, %0d errors", checks, total_errors());
		if (total_errors() == 0)
			$display("PASS: all tests");
		else
			$display("FAIL: see errors above");
		$finish;
	end

endmodule

// ==== all.f ====
+incdir+include
hdl/flash_bus_pkg.sv
hdl/flash_spi_pkg.sv
hdl/flash_port_arbiter.sv
hdl/flash_xfer_sequencer.sv
hdl/flash_shift_datapath.sv
hdl/flash_ctrl_top.sv
dv/spi_flash_model.sv
dv/tb_flash_ctrl.sv

// ==== run.sh ====
#!/bin/bash
# Build and run the flash controller testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f all.f --top-module tb_flash_ctrl -o tb_flash_ctrl
if [ $? -ne 0 ]; then
	echo "Build failed"
	exit 1
fi

output=$(./obj_dir/tb_flash_ctrl)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if echo "$output" | grep -qx "PASS: all tests"; then
	exit 0
fi
exit 1
